// File: dv/timedFlagTb.sv
`timescale 1ns/1ps

module timedFlagTb
   import timedFlagPkg::*;
();

   localparam int clkPeriod   = 8;
   localparam int depth       = 1 << $bits(addr_t);
   localparam int numRandWr   = 64;
   localparam int numRuns     = 6;
   localparam int runBudget   = 16 + 8 * 16 + 8;    // Worst delay plus slow matching.
   localparam int totalCycles = 2 + 2 * (2 * depth + numRandWr) + numRuns * runBudget + 400;
   localparam int timeoutNs   = totalCycles * clkPeriod + 1000;

   logic   clk;
   logic   rst;
   logic   valid;
   strb_t  wstrb;
   addr_t  addr;
   word_t  wdata;
   logic   ready;
   word_t  rdata;
   logic   run;
   logic   running;
   logic   disabled;
   count_t amount;
   count_t delay0;
   word_t  in0;
   word_t  out0;
   logic   done;

   word_t       modelTable [depth];
   count_t      mDelay;
   count_t      mRemaining;
   addr_t       mIndex;
   logic        prevValid;
   logic        prevRead;
   word_t       prevRdata;
   logic [31:0] lfsrState = 32'd66160;

   timedFlagTop UUT (.*);

   initial begin
      clk = 1'b0;
      forever #(clkPeriod / 2) clk = ~clk;
   end

   // Taps 32, 22, 2, 1.
   function automatic logic lfsrStep();
      logic fb;
      fb        = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
      lfsrState = {lfsrState[30:0], fb};
      return fb;
   endfunction

   function automatic logic [31:0] randBits(input int n);
      logic [31:0] r;
      r = '0;
      for (int i = 0; i < n; i++) begin
         r = {r[30:0], lfsrStep()};
      end
      return r;
   endfunction

   task automatic checkWord(input word_t got, input word_t exp, input string what);
      if (got !== exp) begin
         $display("ERROR at %0t ns: %s is %h, expected %h", $time, what, got, exp);
         $display("Errors found");
         $fatal(1, "word mismatch");
      end
   endtask

   task automatic checkBit(input logic got, input logic exp, input string what);
      if (got !== exp) begin
         $display("ERROR at %0t ns: %s is %b, expected %b", $time, what, got, exp);
         $display("Errors found");
         $fatal(1, "bit mismatch");
      end
   endtask

   // Steps the model by one clock edge with the inputs of this cycle.
   task automatic updateModel(input logic match);
      logic adv;
      adv = (mDelay == '0) && (mRemaining != '0) && running && match;
      prevValid = valid;
      if (valid) begin
         prevRead  = (wstrb == '0);
         prevRdata = modelTable[addr];                  // Read before write.
         for (int b = 0; b < $bits(strb_t); b++) begin
            if (wstrb[b]) begin
               modelTable[addr][8*b +: 8] = wdata[8*b +: 8];
            end
         end
      end
      if (run && !disabled) begin
         mDelay     = delay0;
         mRemaining = amount;
      end else if (mDelay != '0) begin
         mDelay = mDelay - count_t'(1);
      end else if (adv) begin
         mRemaining = mRemaining - count_t'(1);
      end
      if (run) begin
         mIndex = '0;                                   // Restart even when disabled.
      end else if (adv) begin
         mIndex = mIndex + addr_t'(1);
      end
   endtask

   // Checks mid cycle, then moves to the next drive point.
   task automatic runCycle();
      logic  match;
      word_t expFlag;
      @(negedge clk);
      match   = (in0 == modelTable[mIndex]);
      expFlag = (mDelay == '0 && !disabled && match) ? '1 : '0;
      checkBit(ready, prevValid, "ready");
      if (prevValid && prevRead) begin
         checkWord(rdata, prevRdata, "rdata");
      end
      checkWord(out0, expFlag, "out0");
      checkBit(done, mRemaining == '0, "done");
      @(posedge clk);
      updateModel(match);
      #1;
   endtask

   task automatic busAccess(input addr_t a, input word_t d, input strb_t s);
      valid = 1'b1;
      addr  = a;
      wdata = d;
      wstrb = s;
      runCycle();
      valid = 1'b0;
      wstrb = '0;
      runCycle();                                       // Idle cycle, no back to back.
   endtask

   task automatic busPhase();
      addr_t a;
      strb_t s;
      for (int i = 0; i < depth; i++) begin
         busAccess(addr_t'(i), randBits(32), '1);
      end
      repeat (numRandWr) begin
         a = addr_t'(randBits($bits(addr_t)));
         s = strb_t'(randBits($bits(strb_t)));
         if (s == '0) begin
            s = strb_t'(1);
         end
         busAccess(a, randBits(32), s);
      end
      for (int i = 0; i < depth; i++) begin
         busAccess(addr_t'(i), '0, '0);
      end
   endtask

   task automatic armRun(input count_t amt, input count_t dly);
      run    = 1'b1;
      amount = amt;
      delay0 = dly;
      runCycle();
      run = 1'b0;
   endtask

   // Input held on entry 0, so out0 stays low only by the delay.
   task automatic waitDelay();
      while (mDelay != '0) begin
         running = 1'b1;
         in0     = modelTable[mIndex];
         runCycle();
      end
   endtask

   task automatic streamCycle(input logic runLevel);
      logic [31:0] noise;
      noise   = randBits(31);
      running = runLevel;
      if (randBits(1) != 0) begin
         in0 = modelTable[mIndex];
      end else begin
         in0 = modelTable[mIndex] ^ {noise[30:0], 1'b1};
      end
      runCycle();
   endtask

   task automatic countToDone();
      while (mRemaining != '0) begin
         streamCycle(1'b1);
      end
      repeat (3) begin
         streamCycle(1'b1);
      end
   endtask

   task automatic disabledRun();
      disabled = 1'b1;
      running  = 1'b0;
      in0      = modelTable[mIndex];
      armRun(count_t'(randBits(4)) + count_t'(20), count_t'(randBits(4)) + count_t'(1));
      repeat (6) begin
         in0 = modelTable[mIndex];                      // Matches, yet no flag.
         runCycle();
      end
      disabled = 1'b0;
   endtask

   initial begin
      #(timeoutNs);
      $display("Watchdog: simulation did not finish within %0d ns", timeoutNs);
      $display("Errors found");
      $fatal(1, "timeout");
   end

   initial begin
      rst        = 1'b1;
      valid      = 1'b0;
      wstrb      = '0;
      addr       = '0;
      wdata      = '0;
      run        = 1'b0;
      running    = 1'b0;
      disabled   = 1'b1;                                // Table not loaded yet.
      amount     = '0;
      delay0     = '0;
      in0        = '0;
      mDelay     = '0;
      mRemaining = '0;
      mIndex     = '0;
      prevValid  = 1'b0;
      prevRead   = 1'b0;
      prevRdata  = '0;
      repeat (2) @(posedge clk);
      #1;
      rst = 1'b0;

      busPhase();
      disabled = 1'b0;

      for (int r = 0; r < numRuns; r++) begin
         armRun(count_t'(randBits(4)) + count_t'(1), count_t'(randBits(4)));
         waitDelay();
         countToDone();
      end

      // Running low holds count and scan.
      armRun(count_t'(8), count_t'(3));
      waitDelay();
      repeat (3) begin
         streamCycle(1'b1);
      end
      repeat (6) begin
         running = 1'b0;
         in0     = modelTable[mIndex];
         runCycle();
      end
      countToDone();

      armRun(count_t'(10), count_t'(2));
      waitDelay();
      repeat (4) begin
         streamCycle(1'b1);
      end
      disabledRun();
      countToDone();

      // Re-arm in the middle of a sequence.
      armRun(count_t'(12), count_t'(1));
      waitDelay();
      repeat (5) begin
         streamCycle(1'b1);
      end
      armRun(count_t'(6), count_t'(4));
      waitDelay();
      countToDone();

      $display("No errors");
      $finish;
   end

endmodule

// File: include/timedFlag_defs.svh
`ifndef TIMED_FLAG_DEFS_SVH
`define TIMED_FLAG_DEFS_SVH

// Data bus and table word width.
`define TF_DATA_W 32

// Table address width, 256 entries.
`define TF_ADDR_W 8

// Amount and delay counter width.
`define TF_CNT_W 32

`endif

// File: list.f
+incdir+include
source/timedFlagPkg.sv
source/memPortIf.sv
source/busWritePort.sv
source/dualPortRam.sv
source/memoryScanner.sv
source/timedFlag.sv
source/timedFlagTop.sv
dv/timedFlagTb.sv

// File: run.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it; a $fatal gives a failing status.

cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal -f list.f --top-module timedFlagTb -o timedFlagSim &&
./obj_dir/timedFlagSim ||
{ echo "Simulation failed"; exit 1; }

// File: source/busWritePort.sv
`timescale 1ns/1ps

module busWritePort
   import timedFlagPkg::*;
(
   input  logic        clk,
   input  logic        rst,

   input  logic        valid,
   input  strb_t       wstrb,
   input  addr_t       addr,
   input  word_t       wdata,
   output logic        ready,
   output word_t       rdata,

   memPortIf.requester mem,
   output strb_t       strb
);

   logic isWrite;
   logic readPending;

   // Zero strobes mean a read.
   assign isWrite = |wstrb;

   // Every strobe becomes exactly one memory access.
   assign mem.addr   = addr;
   assign mem.wdata  = wdata;
   assign mem.enable = valid;
   assign mem.write  = valid & isWrite;
   assign strb       = wstrb;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         ready       <= 1'b0;
         readPending <= 1'b0;
      end else begin
         ready       <= valid;              // One cycle after valid.
         readPending <= valid & ~isWrite;
      end
   end

   // Memory word lines up with ready.
   assign rdata = readPending ? mem.rdata : '0;

endmodule

// File: source/dualPortRam.sv
`timescale 1ns/1ps
`include "timedFlag_defs.svh"

module dualPortRam
   import timedFlagPkg::*;
(
   input  logic     clk,

   memPortIf.memory busPort,
   memPortIf.memory scanPort,

   input  strb_t    strb
);

   localparam int depth    = 1 << `TF_ADDR_W;
   localparam int numBytes = $bits(strb_t);

   word_t entries [depth];

   // Bus side, byte writes and read-before-write.
   always_ff @(posedge clk) begin
      if (busPort.enable) begin
         if (busPort.write) begin
            for (int b = 0; b < numBytes; b++) begin
               if (strb[b]) begin
                  entries[busPort.addr][8*b +: 8] <= busPort.wdata[8*b +: 8];
               end
            end
         end
         busPort.rdata <= entries[busPort.addr];
      end
   end

   // Scan side is read only.
   always_ff @(posedge clk) begin
      if (scanPort.enable) begin
         scanPort.rdata <= entries[scanPort.addr];
      end
   end

endmodule

// File: source/memPortIf.sv
`timescale 1ns/1ps

interface memPortIf
   import timedFlagPkg::*;
();

   addr_t addr;
   word_t wdata;
   word_t rdata;      // Registered read data.
   logic  enable;
   logic  write;      // Only meaningful with enable.

   modport requester (
      output addr,
      output wdata,
      output enable,
      output write,
      input  rdata
   );

   modport memory (
      input  addr,
      input  wdata,
      input  enable,
      input  write,
      output rdata
   );

endinterface

// File: source/memoryScanner.sv
`timescale 1ns/1ps

module memoryScanner
   import timedFlagPkg::*;
(
   input  logic        clk,
   input  logic        rst,

   input  logic        restart,
   input  logic        advance,

   memPortIf.requester mem,
   output word_t       currentValue
);

   addr_t index;
   addr_t nextIndex;

   // Restart wins over advance.
   always_comb begin
      if (restart) begin
         nextIndex = '0;
      end else if (advance) begin
         nextIndex = index + 1'b1;
      end else begin
         nextIndex = index;
      end
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         index <= '0;
      end else begin
         index <= nextIndex;
      end
   end

   // Fetching the next index keeps the read data on the current entry.
   assign mem.addr     = nextIndex;
   assign mem.enable   = 1'b1;
   assign mem.write    = 1'b0;
   assign mem.wdata    = '0;

   assign currentValue = mem.rdata;

endmodule

// File: source/timedFlag.sv
`timescale 1ns/1ps

module timedFlag
   import timedFlagPkg::*;
(
   input  logic   clk,
   input  logic   rst,

   input  logic   run,
   input  logic   running,
   input  logic   disabled,
   input  count_t amount,
   input  count_t delay0,

   input  word_t  in0,
   input  word_t  currentValue,

   output logic   advance,
   output word_t  out0,
   output logic   done
);

   count_t delay;
   count_t remaining;
   logic   match;
   logic   delayDone;
   logic   pending;

   assign match     = (in0 == currentValue);
   assign delayDone = (delay == '0);
   assign pending   = (remaining != '0);

   // The one place where a match is counted.
   assign advance = delayDone & pending & running & match;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         delay     <= '0;
         remaining <= '0;
      end else if (run && !disabled) begin
         delay     <= delay0;              // Arm with fresh values.
         remaining <= amount;
      end else if (!delayDone) begin
         delay     <= delay - 1'b1;
      end else if (advance) begin
         remaining <= remaining - 1'b1;
      end
   end

   // Flag does not depend on running or the count.
   assign out0 = (delayDone && !disabled && match) ? '1 : '0;

   assign done = ~pending;

endmodule

// File: source/timedFlagPkg.sv
package timedFlagPkg;

`include "timedFlag_defs.svh"

   // One data or table word.
   typedef logic [`TF_DATA_W-1:0] word_t;

   // One table address.
   typedef logic [`TF_ADDR_W-1:0] addr_t;

   // Byte write strobes, one bit per byte.
   typedef logic [`TF_DATA_W/8-1:0] strb_t;

   // Amount and delay values.
   typedef logic [`TF_CNT_W-1:0] count_t;

endpackage

// File: source/timedFlagTop.sv
`timescale 1ns/1ps

module timedFlagTop
   import timedFlagPkg::*;
(
   input  logic   clk,
   input  logic   rst,

   input  logic   valid,
   input  strb_t  wstrb,
   input  addr_t  addr,
   input  word_t  wdata,
   output logic   ready,
   output word_t  rdata,

   input  logic   run,
   input  logic   running,
   input  logic   disabled,
   input  count_t amount,
   input  count_t delay0,
   input  word_t  in0,
   output word_t  out0,
   output logic   done
);

   strb_t strb;
   word_t currentValue;
   logic  advance;

   memPortIf busPort ();
   memPortIf scanPort ();

   busWritePort busSide (
      .clk   (clk),
      .rst   (rst),
      .valid (valid),
      .wstrb (wstrb),
      .addr  (addr),
      .wdata (wdata),
      .ready (ready),
      .rdata (rdata),
      .mem   (busPort.requester),
      .strb  (strb)
   );

   dualPortRam ram (
      .clk      (clk),
      .busPort  (busPort.memory),
      .scanPort (scanPort.memory),
      .strb     (strb)
   );

   memoryScanner scanner (
      .clk          (clk),
      .rst          (rst),
      .restart      (run),             // Every run restarts the scan.
      .advance      (advance),
      .mem          (scanPort.requester),
      .currentValue (currentValue)
   );

   timedFlag flagUnit (
      .clk          (clk),
      .rst          (rst),
      .run          (run),
      .running      (running),
      .disabled     (disabled),
      .amount       (amount),
      .delay0       (delay0),
      .in0          (in0),
      .currentValue (currentValue),
      .advance      (advance),
      .out0         (out0),
      .done         (done)
   );

endmodule
